// File: verilog/bbc_mem_pkg.sv
package bbc_mem_pkg;

	// CPU bus widths
	localparam int cpu_addr_w = 16;
	localparam int cpu_data_w = 8;

	// Decoded 64K address map
	typedef enum logic [3:0]
	{
		REG_RAM     = 4'd0,  // 0000-7FFF
		REG_ROM     = 4'd1,  // 8000-BFFF, paged
		REG_MOS     = 4'd2,  // C000-FBFF and FF00-FFFF
		REG_FRED    = 4'd3,  // FCxx
		REG_JIM     = 4'd4,  // FDxx
		REG_CRTC    = 4'd5,  // FE00-FE07
		REG_ACIA    = 4'd6,  // FE08-FE0F
		REG_SERPROC = 4'd7,  // FE10-FE1F
		REG_VIDPROC = 4'd8,  // FE20-FE2F
		REG_ROMSEL  = 4'd9,  // FE30-FE3F
		REG_SYSVIA  = 4'd10, // FE40-FE5F
		REG_USERVIA = 4'd11, // FE60-FE7F
		REG_FDC     = 4'd12, // FE80-FE9F
		REG_ADLC    = 4'd13, // FEA0-FEBF
		REG_ADC     = 4'd14, // FEC0-FEDF
		REG_TUBE    = 4'd15  // FEE0-FEFF
	} region_e;

	// No serial chip fitted, so the ACIA always reads as idle
	// with the transmit register empty
	localparam logic [cpu_data_w-1:0] acia_status_idle = 8'h02;

endpackage

// File: verilog/bbc_video_pkg.sv
package bbc_video_pkg;

	// Display RAM address and CRTC MA widths
	localparam int vid_addr_w = 15;
	localparam int crtc_ma_w = 14;

	// Screen wrap code, IC32 bits 5:4
	// Each value picks the constant added to MA[11:8] when MA[12] is set,
	// so the screen wraps back to its own start instead of past 0x8000
	typedef enum logic [1:0]
	{
		WRAP_MODE3   = 2'b00, // add 8, restart at 0x4000
		WRAP_MODE6   = 2'b01, // add 12, restart at 0x6000
		WRAP_MODE012 = 2'b10, // add 6, restart at 0x3000
		WRAP_MODE45  = 2'b11  // add 11, restart at 0x5800
	} wrap_mode_e;

endpackage

// File: verilog/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if import bbc_mem_pkg::*;;

	logic [cpu_addr_w-1:0] addr;
	logic                  we;
	logic [cpu_data_w-1:0] wdata;
	// High for one clock at the end of each bus cycle
	logic                  clken;
	region_e               region;

	modport decoder
	(
		input  addr,
		output region
	);

	modport latch
	(
		input addr,
		input we,
		input wdata,
		input clken,
		input region
	);

	modport reader
	(
		input region,
		input clken
	);

endinterface

// File: verilog/clock_enables.sv
`timescale 1ns/1ps

module clock_enables
#(
	parameter int CPU_DIV_LOG2 = 4
)
(
	input  logic CLK32M_I,
	input  logic rst_n,
	input  logic slow_access,
	output logic mhz4_clken,
	output logic mhz1_clken,
	output logic cpu_clken
);

	localparam int CNT_W = CPU_DIV_LOG2 + 1;

	logic [CNT_W-1:0] count;
	logic             mhz2_clken;

	// Free-running divider, restarting at 1 so no strobe shows in reset
	always_ff @(posedge CLK32M_I)
	begin
		if (!rst_n)
			count <= {{(CNT_W-1){1'b0}}, 1'b1};
		else
			count <= count + 1'b1;
	end

	assign mhz4_clken = (count[CPU_DIV_LOG2-2:0] == '0);
	assign mhz2_clken = (count[CPU_DIV_LOG2-1:0] == '0);
	assign mhz1_clken = (count == '0);

	// 1 MHz devices only see a strobe on the 1 MHz phase,
	// so a slow cycle ends on the next mhz1 strobe
	assign cpu_clken = mhz2_clken && (!slow_access || mhz1_clken);

	// 1 MHz phase sits on a 4 MHz strobe that came round a 4 MHz period earlier
	a_phase_nesting: assert property
		(@(posedge CLK32M_I) disable iff (!rst_n)
			mhz1_clken |-> mhz4_clken && $past(mhz4_clken, 2 ** (CPU_DIV_LOG2 - 1)))
		else $error("1 MHz strobe outside 4 MHz phase");

	// Slow cycles end one 2 MHz period after the odd 2 MHz strobe
	a_slow_stretch: assert property
		(@(posedge CLK32M_I) disable iff (!rst_n)
			(cpu_clken && slow_access) |->
				$past(mhz2_clken && !mhz1_clken, 2 ** CPU_DIV_LOG2))
		else $error("CPU strobe ended a slow cycle off the 1 MHz phase");

endmodule

// File: verilog/address_decode.sv
`timescale 1ns/1ps

module address_decode import bbc_mem_pkg::*;
(
	cpu_bus_if.decoder bus,
	output logic       slow_access,
	output logic       crtc_cs,
	output logic       vidproc_cs,
	output logic       sys_via_cs,
	output logic       user_via_cs,
	output logic       adc_cs,
	output logic       mem_cs
);

	region_e region;

	always_comb
	begin
		if (!bus.addr[15])
			region = REG_RAM;
		else if (!bus.addr[14])
			region = REG_ROM;
		else if (bus.addr[15:8] == 8'hfc)
			region = REG_FRED;
		else if (bus.addr[15:8] == 8'hfd)
			region = REG_JIM;
		else if (bus.addr[15:8] == 8'hfe)
		begin
			// SHEILA page, decoded in 16 or 32 byte blocks
			case (bus.addr[7:4])
				4'h0:        region = bus.addr[3] ? REG_ACIA : REG_CRTC;
				4'h1:        region = REG_SERPROC;
				4'h2:        region = REG_VIDPROC;
				4'h3:        region = REG_ROMSEL;
				4'h4, 4'h5:  region = REG_SYSVIA;
				4'h6, 4'h7:  region = REG_USERVIA;
				4'h8, 4'h9:  region = REG_FDC;
				4'ha, 4'hb:  region = REG_ADLC;
				4'hc, 4'hd:  region = REG_ADC;
				default:     region = REG_TUBE;
			endcase
		end
		else
			region = REG_MOS;
	end

	assign bus.region = region;

	assign mem_cs = (region == REG_RAM) || (region == REG_ROM) || (region == REG_MOS);
	assign crtc_cs = (region == REG_CRTC);
	assign vidproc_cs = (region == REG_VIDPROC);
	assign sys_via_cs = (region == REG_SYSVIA);
	assign user_via_cs = (region == REG_USERVIA);
	assign adc_cs = (region == REG_ADC);

	// Everything on the 1 MHz bus
	assign slow_access = region inside {REG_FRED, REG_JIM, REG_ACIA, REG_SERPROC,
		REG_SYSVIA, REG_USERVIA, REG_FDC, REG_ADLC, REG_ADC};

	always_comb
	begin
		if (!$isunknown(bus.addr))
		begin
			a_one_select: assert ($onehot0({mem_cs, crtc_cs, vidproc_cs, sys_via_cs,
				user_via_cs, adc_cs}))
				else $error("More than one device select high");
		end
	end

endmodule

// File: verilog/system_latches.sv
`timescale 1ns/1ps

module system_latches import bbc_mem_pkg::*, bbc_video_pkg::*;
(
	input  logic       CLK32M_I,
	input  logic       rst_n,
	cpu_bus_if.latch   bus,
	input  logic [7:0] pb,
	output logic [3:0] romsel,
	output logic       mem_we,
	output wrap_mode_e wrap_mode,
	output logic       sound_we_n,
	output logic       speech_wr_n,
	output logic       speech_rd_n,
	output logic       keyb_autoscan_n,
	output logic       caps_led_n,
	output logic       shift_led_n
);

	logic [7:0] ic32;

	// Paged ROM number, written by the CPU at FE30-FE3F
	always_ff @(posedge CLK32M_I)
	begin
		if (!rst_n)
			romsel <= 4'h0;
		else if (bus.clken && bus.we && (bus.region == REG_ROMSEL))
			romsel <= bus.wdata[3:0];
	end

	// IC32 addressable latch
	// PB2:0 picks the bit, PB3 is the value; the VIA drives it every clock
	always_ff @(posedge CLK32M_I)
	begin
		if (!rst_n)
			ic32 <= 8'h00;
		else
			ic32[pb[2:0]] <= pb[3];
	end

	assign sound_we_n = ic32[0];
	assign speech_wr_n = ic32[1];
	assign speech_rd_n = ic32[2];
	assign keyb_autoscan_n = ic32[3];
	assign wrap_mode = wrap_mode_e'(ic32[5:4]);
	assign caps_led_n = ic32[6];
	assign shift_led_n = ic32[7];

	// Only main RAM takes CPU writes, ROM and MOS are read only
	assign mem_we = bus.we && (bus.region == REG_RAM);

	// Checks the decoder and the latch together against the raw address
	a_romsel_write: assert property
		(@(posedge CLK32M_I) disable iff (!rst_n)
			(romsel != $past(romsel)) |->
				$past(bus.clken && bus.we && (bus.addr[15:4] == 12'hfe3)))
		else $error("ROM select changed outside a write to FE3x");

endmodule

// File: verilog/read_data_mux.sv
`timescale 1ns/1ps

module read_data_mux import bbc_mem_pkg::*;
(
	input  logic                  CLK32M_I,
	input  logic                  rst_n,
	cpu_bus_if.reader             bus,
	input  logic [cpu_data_w-1:0] mem_di,
	input  logic [cpu_data_w-1:0] crtc_do,
	input  logic [cpu_data_w-1:0] sys_via_do,
	input  logic [cpu_data_w-1:0] user_via_do,
	input  logic [cpu_data_w-1:0] adc_do,
	output logic [cpu_data_w-1:0] cpu_rdata
);

	logic [cpu_data_w-1:0] rd_sel;

	always_comb
	begin
		case (bus.region)
			REG_RAM, REG_ROM, REG_MOS: rd_sel = mem_di;
			REG_CRTC:                  rd_sel = crtc_do;
			REG_ACIA:                  rd_sel = acia_status_idle;
			REG_SYSVIA:                rd_sel = sys_via_do;
			REG_USERVIA:               rd_sel = user_via_do;
			REG_ADC:                   rd_sel = adc_do;
			// Undecoded locations read as zero
			default:                   rd_sel = '0;
		endcase
	end

	// CPU takes the byte one bus cycle late
	always_ff @(posedge CLK32M_I)
	begin
		if (!rst_n)
			cpu_rdata <= '0;
		else if (bus.clken)
			cpu_rdata <= rd_sel;
	end

endmodule

// File: verilog/display_address.sv
`timescale 1ns/1ps

module display_address import bbc_video_pkg::*;
(
	input  logic                  CLK32M_I,
	input  logic                  rst_n,
	input  logic [crtc_ma_w-1:0]  crtc_ma,
	input  logic [2:0]            crtc_ra,
	input  wrap_mode_e            wrap_mode,
	output logic [vid_addr_w-1:0] vid_adr
);

	logic [3:0] wrap_add;
	logic [3:0] ma_hi;

	always_comb
	begin
		case (wrap_mode)
			WRAP_MODE3:   wrap_add = 4'd8;
			WRAP_MODE6:   wrap_add = 4'd12;
			WRAP_MODE012: wrap_add = 4'd6;
			default:      wrap_add = 4'd11;
		endcase
	end

	// MA12 flags an address past the end of RAM
	// the nibble sum wraps mod 16 back into the screen
	assign ma_hi = crtc_ma[12] ? (crtc_ma[11:8] + wrap_add) : crtc_ma[11:8];

	always_ff @(posedge CLK32M_I)
	begin
		if (!rst_n)
			vid_adr <= '0;
		else if (!crtc_ma[13])
			// Bitmap modes, 8 scan lines per character row
			vid_adr <= {ma_hi, crtc_ma[7:0], crtc_ra};
		else
			// Teletext, 1K screen at 0x3C00 or 0x7C00
			vid_adr <= {ma_hi[3], 4'b1111, crtc_ma[9:0]};
	end

endmodule

// File: verilog/bbc_glue_top.sv
`timescale 1ns/1ps

module bbc_glue_top import bbc_mem_pkg::*, bbc_video_pkg::*;
#(
	parameter int CPU_DIV_LOG2 = 4
)
(
	input  logic                  CLK32M_I,
	input  logic                  rst_n,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic                  cpu_we,
	input  logic [cpu_data_w-1:0] cpu_wdata,
	input  logic [cpu_data_w-1:0] mem_di,
	input  logic [cpu_data_w-1:0] crtc_do,
	input  logic [cpu_data_w-1:0] sys_via_do,
	input  logic [cpu_data_w-1:0] user_via_do,
	input  logic [cpu_data_w-1:0] adc_do,
	input  logic [7:0]            sys_via_pb,
	input  logic [crtc_ma_w-1:0]  crtc_ma,
	input  logic [2:0]            crtc_ra,
	output logic                  cpu_clken,
	output logic                  mhz4_clken,
	output logic                  mhz1_clken,
	output logic [cpu_data_w-1:0] cpu_rdata,
	output logic                  mem_cs,
	output logic                  mem_we,
	output logic [3:0]            romsel,
	output logic                  crtc_cs,
	output logic                  vidproc_cs,
	output logic                  sys_via_cs,
	output logic                  user_via_cs,
	output logic                  adc_cs,
	output logic [vid_addr_w-1:0] vid_adr,
	output logic                  sound_we_n,
	output logic                  speech_wr_n,
	output logic                  speech_rd_n,
	output logic                  keyb_autoscan_n,
	output logic                  caps_led_n,
	output logic                  shift_led_n
);

	logic       slow_access;
	wrap_mode_e wrap_mode;

	cpu_bus_if bus ();

	assign bus.addr = cpu_addr;
	assign bus.we = cpu_we;
	assign bus.wdata = cpu_wdata;
	assign bus.clken = cpu_clken;

	clock_enables #(.CPU_DIV_LOG2(CPU_DIV_LOG2)) u_clock_enables
	(
		.CLK32M_I    (CLK32M_I),
		.rst_n       (rst_n),
		.slow_access (slow_access),
		.mhz4_clken  (mhz4_clken),
		.mhz1_clken  (mhz1_clken),
		.cpu_clken   (cpu_clken)
	);

	address_decode u_address_decode
	(
		.bus         (bus.decoder),
		.slow_access (slow_access),
		.crtc_cs     (crtc_cs),
		.vidproc_cs  (vidproc_cs),
		.sys_via_cs  (sys_via_cs),
		.user_via_cs (user_via_cs),
		.adc_cs      (adc_cs),
		.mem_cs      (mem_cs)
	);

	system_latches u_system_latches
	(
		.CLK32M_I        (CLK32M_I),
		.rst_n           (rst_n),
		.bus             (bus.latch),
		.pb              (sys_via_pb),
		.romsel          (romsel),
		.mem_we          (mem_we),
		.wrap_mode       (wrap_mode),
		.sound_we_n      (sound_we_n),
		.speech_wr_n     (speech_wr_n),
		.speech_rd_n     (speech_rd_n),
		.keyb_autoscan_n (keyb_autoscan_n),
		.caps_led_n      (caps_led_n),
		.shift_led_n     (shift_led_n)
	);

	read_data_mux u_read_data_mux
	(
		.CLK32M_I    (CLK32M_I),
		.rst_n       (rst_n),
		.bus         (bus.reader),
		.mem_di      (mem_di),
		.crtc_do     (crtc_do),
		.sys_via_do  (sys_via_do),
		.user_via_do (user_via_do),
		.adc_do      (adc_do),
		.cpu_rdata   (cpu_rdata)
	);

	display_address u_display_address
	(
		.CLK32M_I  (CLK32M_I),
		.rst_n     (rst_n),
		.crtc_ma   (crtc_ma),
		.crtc_ra   (crtc_ra),
		.wrap_mode (wrap_mode),
		.vid_adr   (vid_adr)
	);

endmodule

// File: verif/bbc_glue_tb.sv
`timescale 1ns/1ps

module bbc_glue_tb import bbc_mem_pkg::*, bbc_video_pkg::*;
();

	localparam int n_decode = 34;
	localparam int n_romsel = 16;
	localparam int n_ic32 = 48;
	localparam int n_vid = 12;
	localparam int n_read = 16;
	localparam int n_slow = 13;
	// Each bus cycle lasts at most 32 clocks, plus the pin-level tests and margin
	localparam int max_cycles = 32 * (n_decode + 1 + 2 * n_romsel + 2 * n_read + 2 * n_slow)
		+ 2 * n_ic32 + 4 * (3 + 2 * n_vid) + 500;

	logic                  CLK32M_I;
	logic                  rst_n;
	logic [cpu_addr_w-1:0] cpu_addr;
	logic                  cpu_we;
	logic [cpu_data_w-1:0] cpu_wdata;
	logic [cpu_data_w-1:0] mem_di;
	logic [cpu_data_w-1:0] crtc_do;
	logic [cpu_data_w-1:0] sys_via_do;
	logic [cpu_data_w-1:0] user_via_do;
	logic [cpu_data_w-1:0] adc_do;
	logic [7:0]            sys_via_pb;
	logic [crtc_ma_w-1:0]  crtc_ma;
	logic [2:0]            crtc_ra;
	logic                  cpu_clken;
	logic                  mhz4_clken;
	logic                  mhz1_clken;
	logic [cpu_data_w-1:0] cpu_rdata;
	logic                  mem_cs;
	logic                  mem_we;
	logic [3:0]            romsel;
	logic                  crtc_cs;
	logic                  vidproc_cs;
	logic                  sys_via_cs;
	logic                  user_via_cs;
	logic                  adc_cs;
	logic [vid_addr_w-1:0] vid_adr;
	logic                  sound_we_n;
	logic                  speech_wr_n;
	logic                  speech_rd_n;
	logic                  keyb_autoscan_n;
	logic                  caps_led_n;
	logic                  shift_led_n;

	logic [31:0] rng;
	logic [31:0] rnd;
	logic [3:0]  exp_romsel;
	logic [7:0]  exp_ic32;
	logic [7:0]  ic32_seen;
	int          errs [7];
	int          cur_test;
	string       cur_name;
	int          total;
	int          cycles = 0;

	bbc_glue_top #(.CPU_DIV_LOG2(4)) dut (.*);

	// IC32 as seen from outside, bit for bit
	assign ic32_seen = {shift_led_n, caps_led_n, dut.wrap_mode, keyb_autoscan_n,
		speech_rd_n, speech_wr_n, sound_we_n};

	always #4 CLK32M_I = ~CLK32M_I;

	always @(posedge CLK32M_I)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("Timeout: run still going after %0d clocks", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			rng = lfsr_step(rng);
			v = {v[30:0], rng[0]};
		end
		return v;
	endfunction

	// Address map reference
	function automatic region_e ref_region(input logic [15:0] a);
		logic [7:0] off;
		off = a[7:0];
		if (a <= 16'h7fff) return REG_RAM;
		if (a <= 16'hbfff) return REG_ROM;
		if (a <= 16'hfbff || a >= 16'hff00) return REG_MOS;
		if (a <= 16'hfcff) return REG_FRED;
		if (a <= 16'hfdff) return REG_JIM;
		if (off <= 8'h07) return REG_CRTC;
		if (off <= 8'h0f) return REG_ACIA;
		if (off <= 8'h1f) return REG_SERPROC;
		if (off <= 8'h2f) return REG_VIDPROC;
		if (off <= 8'h3f) return REG_ROMSEL;
		if (off <= 8'h5f) return REG_SYSVIA;
		if (off <= 8'h7f) return REG_USERVIA;
		if (off <= 8'h9f) return REG_FDC;
		if (off <= 8'hbf) return REG_ADLC;
		if (off <= 8'hdf) return REG_ADC;
		return REG_TUBE;
	endfunction

	// Order: mem, crtc, vidproc, sys via, user via, adc
	function automatic logic [5:0] expected_selects(input region_e r);
		return {r == REG_RAM || r == REG_ROM || r == REG_MOS, r == REG_CRTC,
			r == REG_VIDPROC, r == REG_SYSVIA, r == REG_USERVIA, r == REG_ADC};
	endfunction

	function automatic logic is_slow(input region_e r);
		return r inside {REG_FRED, REG_JIM, REG_ACIA, REG_SERPROC, REG_SYSVIA,
			REG_USERVIA, REG_FDC, REG_ADLC, REG_ADC};
	endfunction

	function automatic logic [14:0] ref_vid(input logic [13:0] ma, input logic [2:0] ra,
		input wrap_mode_e mode);
		logic [3:0] k;
		logic [3:0] hi;
		case (mode)
			WRAP_MODE3:   k = 4'd8;
			WRAP_MODE6:   k = 4'd12;
			WRAP_MODE012: k = 4'd6;
			default:      k = 4'd11;
		endcase
		hi = ma[11:8];
		if (ma[12])
			hi = hi + k;
		if (!ma[13])
			return {hi, ma[7:0], ra};
		return {hi[3], 4'b1111, ma[9:0]};
	endfunction

	task automatic begin_test(input int idx, input string name);
		cur_test = idx;
		cur_name = name;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		errs[cur_test] = errs[cur_test] + 1;
		$display("FAILED %s, %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
	endtask

	task automatic report_problem(input string msg);
		errs[cur_test] = errs[cur_test] + 1;
		$display("ERROR in %s test: %s", cur_name, msg);
	endtask

	// Returns just after the rising edge that carries a CPU strobe
	task automatic wait_clken();
		@(negedge CLK32M_I);
		while (!cpu_clken)
			@(negedge CLK32M_I);
		@(posedge CLK32M_I);
	endtask

	// One full bus cycle, then the bus goes idle on RAM
	task automatic bus_cycle(input logic [15:0] a, input logic w, input logic [7:0] d);
		wait_clken();
		cpu_addr <= a;
		cpu_we <= w;
		cpu_wdata <= d;
		wait_clken();
		cpu_addr <= 16'h0000;
		cpu_we <= 1'b0;
		@(negedge CLK32M_I);
	endtask

	task automatic reset_dut();
		rst_n <= 1'b0;
		sys_via_pb <= 8'h00;
		@(posedge CLK32M_I);
		@(negedge CLK32M_I);
		exp_romsel = 4'h0;
		exp_ic32 = 8'h00;
		if ({cpu_clken, mhz4_clken, mhz1_clken} !== 3'b000)
			report_mismatch("strobes in reset", 0, {cpu_clken, mhz4_clken, mhz1_clken});
		if (romsel !== 4'h0)
			report_mismatch("romsel in reset", 0, romsel);
		if (ic32_seen !== 8'h00)
			report_mismatch("ic32 in reset", 0, ic32_seen);
		if (cpu_rdata !== 8'h00)
			report_mismatch("cpu_rdata in reset", 0, cpu_rdata);
		if (vid_adr !== 15'h0000)
			report_mismatch("vid_adr in reset", 0, vid_adr);
		@(posedge CLK32M_I);
		rst_n <= 1'b1;
	endtask

	task automatic test_decode();
		logic [15:0] addrs [n_decode];
		logic [5:0]  sel;
		logic        we;
		logic        exp_we;
		region_e     r;
		begin_test(0, "decode");
		addrs = '{16'h0000, 16'h7fff, 16'h8000, 16'hbfff, 16'hc000, 16'hfbff,
			16'hfc00, 16'hfcff, 16'hfd00, 16'hfdff, 16'hfe00, 16'hfe07,
			16'hfe08, 16'hfe0f, 16'hfe10, 16'hfe1f, 16'hfe20, 16'hfe2f,
			16'hfe30, 16'hfe3f, 16'hfe40, 16'hfe5f, 16'hfe60, 16'hfe7f,
			16'hfe80, 16'hfe9f, 16'hfea0, 16'hfebf, 16'hfec0, 16'hfedf,
			16'hfee0, 16'hfeff, 16'hff00, 16'hffff};
		foreach (addrs[i])
		begin
			r = ref_region(addrs[i]);
			// Every other entry is a write, kept away from the ROM select latch
			we = (i % 2 == 1) && (r != REG_ROMSEL);
			exp_we = we && (r == REG_RAM);
			wait_clken();
			cpu_addr <= addrs[i];
			cpu_we <= we;
			@(negedge CLK32M_I);
			sel = {mem_cs, crtc_cs, vidproc_cs, sys_via_cs, user_via_cs, adc_cs};
			if (sel !== expected_selects(r))
				report_mismatch($sformatf("selects at %h", addrs[i]),
					expected_selects(r), sel);
			if (mem_we !== exp_we)
				report_mismatch($sformatf("mem_we at %h", addrs[i]), exp_we, mem_we);
		end
		wait_clken();
		cpu_we <= 1'b0;
	endtask

	task automatic test_romsel();
		logic [15:0] a;
		logic [7:0]  d;
		logic [15:0] others [4];
		begin_test(1, "romsel");
		for (int i = 0; i < n_romsel - 4; i++)
		begin
			rnd = rand_bits(12);
			a = {12'hfe3, rnd[3:0]};
			d = rnd[11:4];
			bus_cycle(a, 1'b1, d);
			exp_romsel = d[3:0];
			if (romsel !== exp_romsel)
				report_mismatch($sformatf("write %h to %h", d, a), exp_romsel, romsel);
		end
		// First one is a read of the latch, the rest are writes next to it
		others = '{16'hfe35, 16'hfe2f, 16'hfe40, 16'h3e30};
		foreach (others[i])
		begin
			bus_cycle(others[i], i != 0, {4'h0, ~exp_romsel});
			if (romsel !== exp_romsel)
				report_mismatch($sformatf("access to %h", others[i]), exp_romsel, romsel);
		end
	endtask

	task automatic test_ic32();
		logic [7:0] v;
		begin_test(2, "ic32");
		for (int i = 0; i < n_ic32; i++)
		begin
			rnd = rand_bits(8);
			v = rnd[7:0];
			@(posedge CLK32M_I);
			sys_via_pb <= v;
			exp_ic32[v[2:0]] = v[3];
			@(posedge CLK32M_I);
			@(negedge CLK32M_I);
			if (ic32_seen !== exp_ic32)
				report_mismatch($sformatf("pb %h", v), exp_ic32, ic32_seen);
		end
		@(posedge CLK32M_I);
		reset_dut();
	endtask

	task automatic test_display();
		wrap_mode_e  mode;
		logic [13:0] ma;
		logic [2:0]  ra;
		begin_test(3, "display");
		for (int m = 0; m < 4; m++)
		begin
			// Wrap code lives in IC32 bits 5:4
			@(posedge CLK32M_I);
			sys_via_pb <= {4'h0, m[0], 3'd4};
			@(posedge CLK32M_I);
			sys_via_pb <= {4'h0, m[1], 3'd5};
			@(posedge CLK32M_I);
			mode = wrap_mode_e'(m[1:0]);
			for (int i = 0; i < n_vid; i++)
			begin
				rnd = rand_bits(15);
				ma = {i[1:0], rnd[11:0]};
				ra = rnd[14:12];
				@(posedge CLK32M_I);
				crtc_ma <= ma;
				crtc_ra <= ra;
				@(posedge CLK32M_I);
				@(negedge CLK32M_I);
				if (vid_adr !== ref_vid(ma, ra, mode))
					report_mismatch($sformatf("mode %0d ma %h ra %0d", m, ma, ra),
						ref_vid(ma, ra, mode), vid_adr);
			end
		end
	endtask

	task automatic test_read();
		logic [15:0] addrs [n_read];
		logic [7:0]  chip [5];
		logic [7:0]  exp_d;
		begin_test(4, "read");
		addrs = '{16'h0100, 16'h9000, 16'he000, 16'hfc00, 16'hfd00, 16'hfe00,
			16'hfe08, 16'hfe10, 16'hfe20, 16'hfe30, 16'hfe40, 16'hfe60,
			16'hfe80, 16'hfea0, 16'hfec0, 16'hfee0};
		foreach (addrs[i])
		begin
			for (int k = 0; k < 5; k++)
			begin
				rnd = rand_bits(8);
				chip[k] = rnd[7:0];
			end
			@(posedge CLK32M_I);
			mem_di <= chip[0];
			crtc_do <= chip[1];
			sys_via_do <= chip[2];
			user_via_do <= chip[3];
			adc_do <= chip[4];
			bus_cycle(addrs[i], 1'b0, 8'h00);
			case (ref_region(addrs[i]))
				REG_RAM, REG_ROM, REG_MOS: exp_d = chip[0];
				REG_CRTC:                  exp_d = chip[1];
				REG_ACIA:                  exp_d = 8'h02;
				REG_SYSVIA:                exp_d = chip[2];
				REG_USERVIA:               exp_d = chip[3];
				REG_ADC:                   exp_d = chip[4];
				default:                   exp_d = 8'h00;
			endcase
			if (cpu_rdata !== exp_d)
				report_mismatch($sformatf("read %h", addrs[i]), exp_d, cpu_rdata);
		end
	endtask

	task automatic test_slow();
		logic [15:0] addrs [n_slow];
		int          n;
		begin_test(5, "slow");
		addrs = '{16'hfc10, 16'hfd80, 16'hfe08, 16'hfe18, 16'hfe50, 16'hfe70,
			16'hfe90, 16'hfeb0, 16'hfed0, 16'h0000, 16'h1234, 16'h7fff, 16'h4000};
		foreach (addrs[i])
		begin
			wait_clken();
			cpu_addr <= addrs[i];
			cpu_we <= 1'b0;
			n = 0;
			do
			begin
				@(negedge CLK32M_I);
				n = n + 1;
			end
			while (!cpu_clken);
			if (!mhz4_clken)
				report_problem($sformatf("strobe at %h missed the 4 MHz phase",
					addrs[i]));
			if (is_slow(ref_region(addrs[i])))
			begin
				if (!mhz1_clken)
					report_problem($sformatf("cycle at %h ended off the 1 MHz phase",
						addrs[i]));
				if (n != 16 && n != 32)
					report_problem($sformatf("cycle at %h lasted %0d clocks",
						addrs[i], n));
			end
			else if (n != 16)
				report_mismatch($sformatf("strobe spacing at %h", addrs[i]), 16, n);
			@(posedge CLK32M_I);
			cpu_addr <= 16'h0000;
		end
	endtask

	initial
	begin
		CLK32M_I = 1'b0;
		rst_n = 1'b0;
		cpu_addr = 16'h0000;
		cpu_we = 1'b0;
		cpu_wdata = 8'h00;
		mem_di = 8'h00;
		crtc_do = 8'h00;
		sys_via_do = 8'h00;
		user_via_do = 8'h00;
		adc_do = 8'h00;
		sys_via_pb = 8'h00;
		crtc_ma = 14'h0000;
		crtc_ra = 3'h0;
		rng = 32'he425_9189;
		foreach (errs[i])
			errs[i] = 0;
		begin_test(6, "reset");
		reset_dut();
		test_decode();
		test_romsel();
		test_ic32();
		test_display();
		test_read();
		test_slow();
		total = 0;
		foreach (errs[i])
			total = total + errs[i];
		$display({"Error counts: decode %0d, romsel %0d, ic32 %0d, display %0d, ",
			"read %0d, slow %0d, reset %0d"},
			errs[0], errs[1], errs[2], errs[3], errs[4], errs[5], errs[6]);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: list.f
verilog/bbc_mem_pkg.sv
verilog/bbc_video_pkg.sv
verilog/cpu_bus_if.sv
verilog/clock_enables.sv
verilog/address_decode.sv
verilog/system_latches.sv
verilog/read_data_mux.sv
verilog/display_address.sv
verilog/bbc_glue_top.sv
verif/bbc_glue_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module bbc_glue_tb -f list.f || exit 1
out=$(./obj_dir/Vbbc_glue_tb)
echo "$out"
echo "$out" | grep -q "^TESTBENCH PASSED$" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
